//--- src/vio_switch_pkg.sv
// Shared port map, widths and destination types of the packet switch, used by scoped name
`default_nettype none

package vio_switch_pkg;

  // Port classes, in the order of the port index
  localparam int N_ID           = 2;
  localparam int N_PORTS        = 2 * N_ID + 1;
  localparam int PORT_VFIU_BASE = 0;
  localparam int PORT_HOST_BASE = N_ID;
  localparam int PORT_NET       = 2 * N_ID;

  // Stream widths
  localparam int DATA_BITS = 32;
  localparam int KEEP_BITS = DATA_BITS / 8;

  // Destination layout, port number sits at bit 10 and up (dest / 1024)
  localparam int DEST_BITS        = 14;
  localparam int DEST_STRIDE_BITS = 10;
  localparam int PORT_BITS        = 3;

  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [KEEP_BITS-1:0] keep_t;
  typedef logic [DEST_BITS-1:0] dest_t;
  typedef logic [PORT_BITS-1:0] port_t;

  // One bit per switch port
  typedef logic [N_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

//--- src/vio_route_decode.sv
// Per-input destination decode, drives one request bit per output and drops unroutable beats
`default_nettype none
`timescale 1ns/1ps

module vio_route_decode (
  input  logic                       tvalid,
  input  vio_switch_pkg::dest_t      tdest,
  input  vio_switch_pkg::port_mask_t out_ready,
  output vio_switch_pkg::port_mask_t req,
  output logic                       tready,
  output logic                       decode_err
);

  localparam int SEL_BITS = vio_switch_pkg::DEST_BITS - vio_switch_pkg::DEST_STRIDE_BITS;

  logic [SEL_BITS-1:0]   port_num;
  logic                  port_ok;
  vio_switch_pkg::port_t port;

  // Full upper field, so that 8..15 is caught as well as 5..7
  assign port_num = tdest[vio_switch_pkg::DEST_BITS-1:vio_switch_pkg::DEST_STRIDE_BITS];
  assign port_ok  = (port_num < vio_switch_pkg::N_PORTS);
  assign port     = port_num[vio_switch_pkg::PORT_BITS-1:0];

  always_comb begin
    req = '0;
    if (tvalid && port_ok) begin
      req[port] = 1'b1;
    end
  end

  assign decode_err = tvalid && !port_ok;

  // Bad beats are accepted at once and vanish
  assign tready = decode_err || (|out_ready);

endmodule

`default_nettype wire

//--- src/vio_out_arbiter.sv
// Per-output round-robin arbiter, grants one input and keeps it until the packet's last beat
`default_nettype none
`timescale 1ns/1ps

module vio_out_arbiter (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  vio_switch_pkg::port_mask_t req,
  input  vio_switch_pkg::port_mask_t s_last,
  input  logic                       m_tready,
  output vio_switch_pkg::port_mask_t grant,
  output logic                       active
);

  typedef enum logic {
    IDLE,
    LOCKED
  } state_t;

  state_t                     state;
  vio_switch_pkg::port_t      grant_idx;
  vio_switch_pkg::port_t      last_idx;
  vio_switch_pkg::port_mask_t pick_mask;
  vio_switch_pkg::port_t      pick_idx;
  logic                       pick_found;
  logic                       last_done;

  // Search starts one past the input served last
  always_comb begin : pick_next
    int idx;
    pick_mask  = '0;
    pick_idx   = last_idx;
    pick_found = 1'b0;
    for (int k = 1; k <= vio_switch_pkg::N_PORTS; k++) begin
      idx = (int'(last_idx) + k) % vio_switch_pkg::N_PORTS;
      if (!pick_found && req[idx]) begin
        pick_found     = 1'b1;
        pick_mask[idx] = 1'b1;
        pick_idx       = vio_switch_pkg::port_t'(idx);
      end
    end
  end

  // Request doubles as the granted input's valid toward this output
  assign last_done = m_tready && req[grant_idx] && s_last[grant_idx];

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state     <= IDLE;
      grant     <= '0;
      grant_idx <= '0;
      last_idx  <= vio_switch_pkg::port_t'(vio_switch_pkg::N_PORTS - 1);
    end else begin
      case (state)
        IDLE: begin
          if (pick_found) begin
            grant     <= pick_mask;
            grant_idx <= pick_idx;
            state     <= LOCKED;
          end
        end
        LOCKED: begin
          // Packet finished, release and advance the pointer
          if (last_done) begin
            grant    <= '0;
            last_idx <= grant_idx;
            state    <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
          grant <= '0;
        end
      endcase
    end
  end

  assign active = (state == LOCKED);

endmodule

`default_nettype wire

//--- src/vio_out_mux.sv
// Per-output payload select, forwards the granted input and returns ready to it alone
`default_nettype none
`timescale 1ns/1ps

module vio_out_mux (
  input  vio_switch_pkg::port_mask_t grant,
  input  logic                       active,
  input  vio_switch_pkg::port_mask_t s_tvalid,
  input  vio_switch_pkg::data_t      s_tdata [vio_switch_pkg::N_PORTS],
  input  vio_switch_pkg::keep_t      s_tkeep [vio_switch_pkg::N_PORTS],
  input  vio_switch_pkg::port_mask_t s_tlast,
  input  vio_switch_pkg::dest_t      s_tdest [vio_switch_pkg::N_PORTS],
  input  logic                       m_tready,
  output vio_switch_pkg::port_mask_t in_ready,
  output logic                       m_tvalid,
  output logic                       m_tlast,
  output vio_switch_pkg::data_t      m_tdata,
  output vio_switch_pkg::keep_t      m_tkeep,
  output vio_switch_pkg::dest_t      m_tdest
);

  // Grant is one-hot, so at most one input lands here
  always_comb begin
    m_tdata = '0;
    m_tkeep = '0;
    m_tdest = '0;
    m_tlast = 1'b0;
    for (int i = 0; i < vio_switch_pkg::N_PORTS; i++) begin
      if (grant[i]) begin
        m_tdata = s_tdata[i];
        m_tkeep = s_tkeep[i];
        m_tdest = s_tdest[i];
        m_tlast = s_tlast[i];
      end
    end
  end

  assign m_tvalid = active && (|(grant & s_tvalid));
  assign in_ready = active ? (grant & {vio_switch_pkg::N_PORTS{m_tready}}) : '0;

endmodule

`default_nettype wire

//--- src/vio_switch.sv
// Five-port stream switch top, routes region, host and network inputs to per-output arbiters
`default_nettype none
`timescale 1ns/1ps

module vio_switch (
  input  logic                       aclk,
  input  logic                       rst_n,

  // Inputs, index 0..1 region, 2..3 host, 4 network
  input  vio_switch_pkg::port_mask_t s_tvalid,
  output vio_switch_pkg::port_mask_t s_tready,
  input  vio_switch_pkg::data_t      s_tdata [vio_switch_pkg::N_PORTS],
  input  vio_switch_pkg::keep_t      s_tkeep [vio_switch_pkg::N_PORTS],
  input  vio_switch_pkg::port_mask_t s_tlast,
  input  vio_switch_pkg::dest_t      route_in [vio_switch_pkg::N_ID],
  input  vio_switch_pkg::dest_t      net_tdest,

  // Outputs, region entries of m_tdest act as route_out
  output vio_switch_pkg::port_mask_t m_tvalid,
  input  vio_switch_pkg::port_mask_t m_tready,
  output vio_switch_pkg::data_t      m_tdata [vio_switch_pkg::N_PORTS],
  output vio_switch_pkg::keep_t      m_tkeep [vio_switch_pkg::N_PORTS],
  output vio_switch_pkg::port_mask_t m_tlast,
  output vio_switch_pkg::dest_t      m_tdest [vio_switch_pkg::N_PORTS],
  output vio_switch_pkg::port_mask_t decode_err
);

  localparam int NP = vio_switch_pkg::N_PORTS;

  vio_switch_pkg::dest_t      s_tdest   [NP];
  vio_switch_pkg::port_mask_t req_in    [NP];  // per input, bit per output
  vio_switch_pkg::port_mask_t req_out   [NP];  // per output, bit per input
  vio_switch_pkg::port_mask_t rdy_out   [NP];  // per output, bit per input
  vio_switch_pkg::port_mask_t rdy_in    [NP];  // per input, bit per output
  vio_switch_pkg::port_mask_t grant     [NP];
  vio_switch_pkg::port_mask_t active;

  // Region inputs follow route_in, host k always lands on region k
  for (genvar i = 0; i < vio_switch_pkg::N_ID; i++) begin : g_dest
    assign s_tdest[vio_switch_pkg::PORT_VFIU_BASE + i] = route_in[i];
    assign s_tdest[vio_switch_pkg::PORT_HOST_BASE + i] =
      vio_switch_pkg::dest_t'((vio_switch_pkg::PORT_VFIU_BASE + i)
                              << vio_switch_pkg::DEST_STRIDE_BITS);
  end
  assign s_tdest[vio_switch_pkg::PORT_NET] = net_tdest;

  // Request and ready cross between input and output order
  for (genvar i = 0; i < NP; i++) begin : g_xpose_row
    for (genvar j = 0; j < NP; j++) begin : g_xpose_col
      assign req_out[j][i] = req_in[i][j];
      assign rdy_in[i][j]  = rdy_out[j][i];
    end
  end

  for (genvar i = 0; i < NP; i++) begin : g_in
    vio_route_decode u_decode (
      .tvalid     (s_tvalid[i]),
      .tdest      (s_tdest[i]),
      .out_ready  (rdy_in[i]),
      .req        (req_in[i]),
      .tready     (s_tready[i]),
      .decode_err (decode_err[i])
    );
  end

  for (genvar j = 0; j < NP; j++) begin : g_out
    vio_out_arbiter u_arbiter (
      .aclk     (aclk),
      .rst_n    (rst_n),
      .req      (req_out[j]),
      .s_last   (s_tlast),
      .m_tready (m_tready[j]),
      .grant    (grant[j]),
      .active   (active[j])
    );

    vio_out_mux u_mux (
      .grant    (grant[j]),
      .active   (active[j]),
      .s_tvalid (s_tvalid),
      .s_tdata  (s_tdata),
      .s_tkeep  (s_tkeep),
      .s_tlast  (s_tlast),
      .s_tdest  (s_tdest),
      .m_tready (m_tready[j]),
      .in_ready (rdy_out[j]),
      .m_tvalid (m_tvalid[j]),
      .m_tlast  (m_tlast[j]),
      .m_tdata  (m_tdata[j]),
      .m_tkeep  (m_tkeep[j]),
      .m_tdest  (m_tdest[j])
    );
  end

endmodule

`default_nettype wire

//--- dv/vio_switch_asserts.sv
// Concurrent checks on the switch outputs and decoders, attached to the top level by bind
`default_nettype none
`timescale 1ns/1ps

module vio_switch_asserts (
  input logic                       aclk,
  input logic                       rst_n,
  input vio_switch_pkg::port_mask_t m_tvalid,
  input vio_switch_pkg::port_mask_t m_tready,
  input vio_switch_pkg::port_mask_t m_tlast,
  input vio_switch_pkg::data_t      m_tdata [vio_switch_pkg::N_PORTS],
  input vio_switch_pkg::keep_t      m_tkeep [vio_switch_pkg::N_PORTS],
  input vio_switch_pkg::dest_t      m_tdest [vio_switch_pkg::N_PORTS],
  input vio_switch_pkg::port_mask_t grant [vio_switch_pkg::N_PORTS],
  input vio_switch_pkg::port_mask_t req_in [vio_switch_pkg::N_PORTS],
  input vio_switch_pkg::port_mask_t decode_err
);

  int fail_count = 0;

  for (genvar j = 0; j < vio_switch_pkg::N_PORTS; j++) begin : g_port
    // A stalled beat stays on the output unchanged
    hold_a: assert property (@(posedge aclk) disable iff (!rst_n)
      m_tvalid[j] && !m_tready[j] |=> m_tvalid[j] && $stable(m_tdata[j]) &&
        $stable(m_tkeep[j]) && $stable(m_tlast[j]) && $stable(m_tdest[j]))
      else begin
        fail_count++;
        $error("output %0d dropped or changed a stalled beat", j);
      end

    // Grant may only move after the last beat
    lock_a: assert property (@(posedge aclk) disable iff (!rst_n)
      m_tvalid[j] && m_tready[j] && !m_tlast[j] |=> $stable(grant[j]))
      else begin
        fail_count++;
        $error("output %0d switched source inside a packet", j);
      end

    err_a: assert property (@(posedge aclk) disable iff (!rst_n)
      !(decode_err[j] && (|req_in[j])))
      else begin
        fail_count++;
        $error("input %0d raised decode_err and a request together", j);
      end
  end

endmodule

bind vio_switch vio_switch_asserts u_asserts (
  .aclk       (aclk),
  .rst_n      (rst_n),
  .m_tvalid   (m_tvalid),
  .m_tready   (m_tready),
  .m_tlast    (m_tlast),
  .m_tdata    (m_tdata),
  .m_tkeep    (m_tkeep),
  .m_tdest    (m_tdest),
  .grant      (grant),
  .req_in     (req_in),
  .decode_err (decode_err)
);

`default_nettype wire

//--- dv/vio_switch_tb.sv
// Testbench for the switch top, runs the packet list from the data file under random back-pressure
`default_nettype none
`timescale 1ns/1ps

module vio_switch_tb;

  localparam int NP            = vio_switch_pkg::N_PORTS;
  localparam int N_ID          = vio_switch_pkg::N_ID;
  localparam int MAX_PKTS      = 64;
  localparam int BEAT_W        = vio_switch_pkg::DEST_BITS + 1 + vio_switch_pkg::DATA_BITS;
  localparam int BEAT_TIMEOUT  = 2000;
  localparam int RUN_TIMEOUT   = 50000;
  localparam int DRAIN_TIMEOUT = 200;

  logic                       aclk = 1'b0;
  logic                       rst_n;
  vio_switch_pkg::port_mask_t s_tvalid;
  vio_switch_pkg::port_mask_t s_tready;
  vio_switch_pkg::data_t      s_tdata [NP];
  vio_switch_pkg::keep_t      s_tkeep [NP];
  vio_switch_pkg::port_mask_t s_tlast;
  vio_switch_pkg::dest_t      route_in [N_ID];
  vio_switch_pkg::dest_t      net_tdest;
  vio_switch_pkg::port_mask_t m_tvalid;
  vio_switch_pkg::port_mask_t m_tready;
  vio_switch_pkg::data_t      m_tdata [NP];
  vio_switch_pkg::keep_t      m_tkeep [NP];
  vio_switch_pkg::port_mask_t m_tlast;
  vio_switch_pkg::dest_t      m_tdest [NP];
  vio_switch_pkg::port_mask_t decode_err;

  // Packet table from the data file
  int                    pkt_count = 0;
  int                    pkt_src  [MAX_PKTS];
  vio_switch_pkg::dest_t pkt_dest [MAX_PKTS];
  int                    pkt_len  [MAX_PKTS];
  vio_switch_pkg::data_t pkt_data [MAX_PKTS];

  // Expected beats {dest, last, data}, one queue per source and output
  logic [BEAT_W-1:0] exp_q [NP][NP][$];
  int                cur_src [NP];
  logic [31:0]       lfsr_state = 32'hca566110;
  int                mismatch_count = 0;
  int                error_count = 0;
  int                timeout_count = 0;
  int                done_count = 0;

  vio_switch u_vio_switch (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .s_tkeep    (s_tkeep),
    .s_tlast    (s_tlast),
    .route_in   (route_in),
    .net_tdest  (net_tdest),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tlast    (m_tlast),
    .m_tdest    (m_tdest),
    .decode_err (decode_err)
  );

  always #10 aclk = ~aclk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  function automatic int pending_beats();
    int total;
    total = 0;
    for (int i = 0; i < NP; i++) begin
      for (int j = 0; j < NP; j++) begin
        total += exp_q[i][j].size();
      end
    end
    return total;
  endfunction

  // Sends every packet of one source in file order
  task automatic drive_source(input int src);
    vio_switch_pkg::dest_t dest;
    int                    out_port;
    int                    wait_cycles;
    logic                  accepted;
    for (int p = 0; p < pkt_count; p++) begin
      if (pkt_src[p] == src) begin
        // Host k always targets region k
        if (src >= vio_switch_pkg::PORT_HOST_BASE && src < vio_switch_pkg::PORT_NET) begin
          dest = vio_switch_pkg::dest_t'((src - vio_switch_pkg::PORT_HOST_BASE) * 1024);
        end else begin
          dest = pkt_dest[p];
        end
        out_port = int'(dest) / 1024;
        if (out_port < NP) begin
          for (int k = 0; k < pkt_len[p]; k++) begin
            exp_q[src][out_port].push_back({dest, (k == pkt_len[p] - 1),
                                            vio_switch_pkg::data_t'(pkt_data[p] + k)});
          end
        end
        for (int k = 0; k < pkt_len[p]; k++) begin
          @(negedge aclk);
          s_tvalid[src] = 1'b1;
          s_tdata[src]  = vio_switch_pkg::data_t'(pkt_data[p] + k);
          s_tkeep[src]  = '1;
          s_tlast[src]  = (k == pkt_len[p] - 1);
          if (src < N_ID) begin
            route_in[src] = dest;
          end else if (src == vio_switch_pkg::PORT_NET) begin
            net_tdest = dest;
          end
          accepted    = 1'b0;
          wait_cycles = 0;
          while (!accepted && wait_cycles < BEAT_TIMEOUT) begin
            @(posedge aclk);
            wait_cycles++;
            accepted = s_tready[src];
            if (out_port < NP) begin
              check_value($sformatf("decode_err[%0d]", src), 1'b0, decode_err[src]);
            end else begin
              // Unroutable beats drain in the cycle they appear
              check_value($sformatf("decode_err[%0d]", src), 1'b1, decode_err[src]);
              check_value($sformatf("s_tready[%0d]", src), 1'b1, s_tready[src]);
            end
          end
          if (!accepted) begin
            $display("Timeout: input %0d never accepted beat %0d of packet %0d", src, k, p);
            timeout_count++;
            s_tvalid[src] = 1'b0;
            done_count++;
            return;
          end
        end
        @(negedge aclk);
        s_tvalid[src] = 1'b0;
        s_tlast[src]  = 1'b0;
      end
    end
    done_count++;
  endtask

  // Random back-pressure, ready about three cycles in four
  initial begin : ready_gen
    logic bit_a;
    logic bit_b;
    m_tready = '1;
    forever begin
      @(negedge aclk);
      for (int j = 0; j < NP; j++) begin
        lfsr_state  = lfsr_step(lfsr_state);
        bit_a       = lfsr_state[0];
        lfsr_state  = lfsr_step(lfsr_state);
        bit_b       = lfsr_state[0];
        m_tready[j] = bit_a | bit_b;
      end
    end
  end

  // Output scoreboard, the first beat picks the source and the rest must follow it
  always @(posedge aclk) begin : out_monitor
    logic [BEAT_W-1:0] beat;
    logic [BEAT_W-1:0] want;
    int                hit;
    if (rst_n) begin
      for (int j = 0; j < NP; j++) begin
        if (m_tvalid[j] && m_tready[j]) begin
          beat = {m_tdest[j], m_tlast[j], m_tdata[j]};
          hit  = cur_src[j];
          for (int i = 0; i < NP; i++) begin
            if (hit < 0 && exp_q[i][j].size() > 0 && exp_q[i][j][0] == beat) begin
              hit = i;
            end
          end
          if (hit < 0 || exp_q[hit][j].size() == 0) begin
            $display("Error at %0t: output %0d carried data %0h that no source had pending",
                     $time, j, m_tdata[j]);
            error_count++;
          end else begin
            want = exp_q[hit][j].pop_front();
            check_value($sformatf("m_tdata[%0d]", j), want[31:0], m_tdata[j]);
            check_value($sformatf("m_tlast[%0d]", j), want[32], m_tlast[j]);
            check_value($sformatf("m_tdest[%0d]", j), want[BEAT_W-1:33], m_tdest[j]);
            check_value($sformatf("m_tkeep[%0d]", j), vio_switch_pkg::keep_t'('1), m_tkeep[j]);
            cur_src[j] = m_tlast[j] ? -1 : hit;
          end
        end
      end
    end
  end

  initial begin : main
    int    fd;
    int    f_src;
    int    f_dest;
    int    f_len;
    int    f_data;
    int    wait_cycles;
    int    assert_fails;
    string line;
    rst_n     = 1'b0;
    s_tvalid  = '0;
    s_tlast   = '0;
    net_tdest = '0;
    for (int i = 0; i < NP; i++) begin
      s_tdata[i] = '0;
      s_tkeep[i] = '0;
      cur_src[i] = -1;
    end
    for (int i = 0; i < N_ID; i++) begin
      route_in[i] = '0;
    end

    fd = $fopen("dv/vio_switch_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the packet list dv/vio_switch_tests.txt");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0 &&
            $sscanf(line, "%h %h %h %h", f_src, f_dest, f_len, f_data) == 4 &&
            pkt_count < MAX_PKTS) begin
          pkt_src[pkt_count]  = f_src;
          pkt_dest[pkt_count] = vio_switch_pkg::dest_t'(f_dest);
          pkt_len[pkt_count]  = f_len;
          pkt_data[pkt_count] = vio_switch_pkg::data_t'(f_data);
          pkt_count++;
        end
      end
      $fclose(fd);
    end
    if (pkt_count == 0) begin
      $display("The packet list holds no packets");
      error_count++;
    end

    // A routable beat waits on region 0 while reset is held and must not be taken
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    s_tkeep[0]  = '1;
    s_tlast[0]  = 1'b1;
    s_tvalid[0] = 1'b1;
    repeat (8) @(posedge aclk);
    check_value("m_tvalid", '0, m_tvalid);
    check_value("s_tready", '0, s_tready);
    check_value("decode_err", '0, decode_err);
    @(negedge aclk);
    s_tvalid[0] = 1'b0;
    s_tlast[0]  = 1'b0;
    rst_n = 1'b1;

    for (int s = 0; s < NP; s++) begin
      automatic int src = s;
      fork
        drive_source(src);
      join_none
    end

    wait_cycles = 0;
    while (done_count < NP && wait_cycles < RUN_TIMEOUT) begin
      @(posedge aclk);
      wait_cycles++;
    end
    if (done_count < NP) begin
      $display("Timeout: only %0d of %0d sources finished sending", done_count, NP);
      timeout_count++;
    end

    wait_cycles = 0;
    while (pending_beats() > 0 && wait_cycles < DRAIN_TIMEOUT) begin
      @(posedge aclk);
      wait_cycles++;
    end
    if (pending_beats() > 0) begin
      $display("Timeout: %0d expected beats never left the switch", pending_beats());
      timeout_count++;
    end

    assert_fails = u_vio_switch.u_asserts.fail_count;
    $display("Errors: %0d mismatches, %0d other, %0d timeouts, %0d assertion failures",
             mismatch_count, error_count, timeout_count, assert_fails);
    if (mismatch_count + error_count + timeout_count + assert_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
src/vio_switch_pkg.sv
src/vio_route_decode.sv
src/vio_out_arbiter.sv
src/vio_out_mux.sv
src/vio_switch.sv
dv/vio_switch_asserts.sv
dv/vio_switch_tb.sv

//--- dv/vio_switch_tests.txt
# Packet list, one packet per line, all columns hex: src dest len first_data
# src 0-1 region, 2-3 host (dest ignored), 4 network; dest / 1024 picks the output
0 0423 3 10000000
1 0000 2 11000000
2 0000 4 12000000
3 0000 3 13000000
4 0800 2 14000000
0 1000 5 10010000
1 0c11 1 11010000
2 0000 2 12010000
3 3c00 4 13010000
4 0000 6 14010000
0 1400 3 10020000
1 3c00 2 11020000
2 0000 3 12020000
3 0000 2 13020000
4 0400 3 14020000
0 0805 2 10030000
1 0400 4 11030000
4 0c00 2 14030000
4 1000 4 14040000
4 1c00 3 14050000
0 0000 4 10040000
1 1000 2 11040000
4 0000 5 14060000
0 0c00 3 10050000
